//--- design/i2c_pkg.sv
package i2c_pkg;

    // scl runs at CLK / (4 * SCL_QUARTER)
    localparam int SCL_QUARTER = 4;
    localparam int SCL_QW = $clog2(SCL_QUARTER);
    localparam logic [SCL_QW-1:0] SCL_QLAST = SCL_QW'(SCL_QUARTER - 1);

    localparam logic [3:0] ACK_BIT = 4'd8; // ninth clock of a byte

    typedef enum logic [2:0] {
        OP_START,
        OP_RESTART,
        OP_WRITE,
        OP_READ,
        OP_STOP
    } byte_op_e;

    typedef struct packed {
        byte_op_e   opcode;
        logic [7:0] data;       // shifted out on OP_WRITE
        logic       master_ack; // OP_READ only, 1 = ack
    } byte_op_t;

    typedef struct packed {
        logic [7:0] data;
        logic       slave_ack; // valid after OP_WRITE
    } byte_rsp_t;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_START, // start and repeated start
        ENG_XFER,  // nine bit periods
        ENG_STOP
    } eng_state_e;

endpackage

//--- design/eeprom_pkg.sv
package eeprom_pkg;

    localparam int EE_ADDR_W = 11;
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // register window
    localparam logic [3:0] REG_ADDR   = 4'h0;
    localparam logic [3:0] REG_WDATA  = 4'h4;
    localparam logic [3:0] REG_CTRL   = 4'h8;
    localparam logic [3:0] REG_STATUS = 4'hC;

    localparam int CTRL_WR_BIT = 0;
    localparam int CTRL_RD_BIT = 1;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic {
        XFER_WRITE,
        XFER_READ
    } xfer_op_e;

    typedef struct packed {
        xfer_op_e             op;
        logic [EE_ADDR_W-1:0] addr;
        logic [7:0]           wdata;
    } eeprom_cmd_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       nack_error;
    } eeprom_rsp_t;

    typedef enum logic [3:0] {
        SEQ_IDLE,
        SEQ_START,
        SEQ_CTRL_WR,
        SEQ_ADDR,
        SEQ_DATA,
        SEQ_RESTART,
        SEQ_CTRL_RD,
        SEQ_READ,
        SEQ_STOP
    } seq_state_e;

endpackage

//--- design/eeprom_axil_regs.sv
`timescale 1ns/1ps

module eeprom_axil_regs (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic [3:0]              awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [3:0]              araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    output logic                    cmd_valid,
    input  logic                    cmd_ready,
    output eeprom_pkg::eeprom_cmd_t cmd,
    input  logic                    rsp_valid,
    input  eeprom_pkg::eeprom_rsp_t rsp
);

    logic [eeprom_pkg::EE_ADDR_W-1:0] addr_reg;
    logic [7:0] wdata_reg;
    logic [7:0] rd_byte;
    logic busy;
    logic nack_err;
    logic wr_go;
    logic rd_go;
    logic ctrl_go;

    // address and data are taken together
    assign awready = !bvalid && wvalid;
    assign wready  = !bvalid && awvalid;
    assign arready = !rvalid;

    assign wr_go = awvalid && wvalid && !bvalid;
    assign rd_go = arvalid && !rvalid;

    assign ctrl_go = wr_go && (awaddr == eeprom_pkg::REG_CTRL) && wstrb[0] && !busy
                     && (wdata[eeprom_pkg::CTRL_WR_BIT] || wdata[eeprom_pkg::CTRL_RD_BIT]);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
            busy      <= 1'b0;
            cmd_valid <= 1'b0;
            nack_err  <= 1'b0;
            rd_byte   <= 8'h00;
        end
        else
        begin
            if (wr_go)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;

            if (rd_go)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;

            if (ctrl_go)
            begin
                busy      <= 1'b1;
                cmd_valid <= 1'b1;
            end
            else if (cmd_ready)
                cmd_valid <= 1'b0;

            if (rsp_valid)
            begin
                busy     <= 1'b0;
                nack_err <= rsp.nack_error;
                rd_byte  <= rsp.rdata;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (wr_go)
        begin
            bresp <= eeprom_pkg::RESP_OKAY;
            case (awaddr)
                eeprom_pkg::REG_ADDR:
                begin
                    if (wstrb[0])
                        addr_reg[7:0] <= wdata[7:0];
                    if (wstrb[1])
                        addr_reg[10:8] <= wdata[10:8];
                end
                eeprom_pkg::REG_WDATA:
                begin
                    if (wstrb[0])
                        wdata_reg <= wdata[7:0];
                end
                eeprom_pkg::REG_CTRL, eeprom_pkg::REG_STATUS: ; // status is read only
                default: bresp <= eeprom_pkg::RESP_SLVERR;
            endcase
        end

        if (ctrl_go)
        begin
            // write wins when both bits are set
            cmd.op    <= wdata[eeprom_pkg::CTRL_WR_BIT] ? eeprom_pkg::XFER_WRITE
                                                        : eeprom_pkg::XFER_READ;
            cmd.addr  <= addr_reg;
            cmd.wdata <= wdata_reg;
        end

        if (rd_go)
        begin
            rresp <= eeprom_pkg::RESP_OKAY;
            rdata <= 32'h0;
            case (araddr)
                eeprom_pkg::REG_ADDR:   rdata <= 32'(addr_reg);
                eeprom_pkg::REG_WDATA:  rdata <= 32'(wdata_reg);
                eeprom_pkg::REG_CTRL:   ; // start bits self clear
                eeprom_pkg::REG_STATUS: rdata <= {16'h0, rd_byte, 6'h0, nack_err, busy};
                default:                rresp <= eeprom_pkg::RESP_SLVERR;
            endcase
        end
    end

    // sequencer must already be idle when a new command appears
    assert property (@(posedge CLK) disable iff (RESET) $rose(cmd_valid) |-> cmd_ready)
        else $error("command launched while the sequencer is busy");

endmodule

//--- design/eeprom_sequencer.sv
`timescale 1ns/1ps

module eeprom_sequencer (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  eeprom_pkg::eeprom_cmd_t cmd,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    op_valid,
    input  logic                    op_ready,
    output i2c_pkg::byte_op_t       op,
    input  logic                    op_done,
    input  i2c_pkg::byte_rsp_t      op_rsp
);

    eeprom_pkg::seq_state_e  state;
    eeprom_pkg::eeprom_cmd_t cmd_r;
    eeprom_pkg::eeprom_rsp_t rsp_r;
    logic       pending; // byte op handed to the engine
    logic [7:0] ctrl_byte;
    logic       slave_nack;

    assign cmd_ready = (state == eeprom_pkg::SEQ_IDLE);
    assign op_valid  = (state != eeprom_pkg::SEQ_IDLE) && !pending;
    assign rsp       = rsp_r;

    // r/w bit is high only for the second control byte of a read
    assign ctrl_byte = {eeprom_pkg::DEVICE_CODE, cmd_r.addr[10:8],
                        state == eeprom_pkg::SEQ_CTRL_RD};

    assign slave_nack = (op.opcode == i2c_pkg::OP_WRITE) && !op_rsp.slave_ack;

    always_comb
    begin
        op.opcode     = i2c_pkg::OP_WRITE;
        op.data       = 8'h00;
        op.master_ack = 1'b0; // single byte read ends in nack
        case (state)
            eeprom_pkg::SEQ_START:   op.opcode = i2c_pkg::OP_START;
            eeprom_pkg::SEQ_CTRL_WR: op.data = ctrl_byte;
            eeprom_pkg::SEQ_CTRL_RD: op.data = ctrl_byte;
            eeprom_pkg::SEQ_ADDR:    op.data = cmd_r.addr[7:0];
            eeprom_pkg::SEQ_DATA:    op.data = cmd_r.wdata;
            eeprom_pkg::SEQ_RESTART: op.opcode = i2c_pkg::OP_RESTART;
            eeprom_pkg::SEQ_READ:    op.opcode = i2c_pkg::OP_READ;
            default:                 op.opcode = i2c_pkg::OP_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::SEQ_IDLE;
            pending   <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= 1'b0;
            if (state == eeprom_pkg::SEQ_IDLE)
            begin
                if (cmd_valid)
                    state <= eeprom_pkg::SEQ_START;
            end
            else if (!pending)
            begin
                if (op_ready)
                    pending <= 1'b1;
            end
            else if (op_done)
            begin
                pending <= 1'b0;
                if (slave_nack)
                    state <= eeprom_pkg::SEQ_STOP; // abort, bus released by stop
                else
                begin
                    case (state)
                        eeprom_pkg::SEQ_START:   state <= eeprom_pkg::SEQ_CTRL_WR;
                        eeprom_pkg::SEQ_CTRL_WR: state <= eeprom_pkg::SEQ_ADDR;
                        eeprom_pkg::SEQ_ADDR:
                        begin
                            if (cmd_r.op == eeprom_pkg::XFER_WRITE)
                                state <= eeprom_pkg::SEQ_DATA;
                            else
                                state <= eeprom_pkg::SEQ_RESTART;
                        end
                        eeprom_pkg::SEQ_DATA:    state <= eeprom_pkg::SEQ_STOP;
                        eeprom_pkg::SEQ_RESTART: state <= eeprom_pkg::SEQ_CTRL_RD;
                        eeprom_pkg::SEQ_CTRL_RD: state <= eeprom_pkg::SEQ_READ;
                        eeprom_pkg::SEQ_READ:    state <= eeprom_pkg::SEQ_STOP;
                        default:
                        begin
                            state     <= eeprom_pkg::SEQ_IDLE;
                            rsp_valid <= 1'b1;
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_valid && cmd_ready)
        begin
            cmd_r            <= cmd;
            rsp_r.nack_error <= 1'b0;
        end
        if (pending && op_done)
        begin
            if (state == eeprom_pkg::SEQ_READ)
                rsp_r.rdata <= op_rsp.data;
            if (slave_nack)
                rsp_r.nack_error <= 1'b1;
        end
    end

    // engine completions must match an issued byte op
    assert property (@(posedge CLK) disable iff (RESET) op_done |-> pending)
        else $error("byte done without an operation outstanding");

endmodule

//--- design/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               op_valid,
    output logic               op_ready,
    input  i2c_pkg::byte_op_t  op,
    output logic               op_done,
    output i2c_pkg::byte_rsp_t op_rsp,
    output logic               scl,
    output logic               sda_drive_low,
    input  logic               sda_in
);

    i2c_pkg::eng_state_e state, state_n;
    logic [i2c_pkg::SCL_QW-1:0] q_cnt, q_n;
    logic [1:0] phase, phase_n;   // quarters of one scl period
    logic [3:0] bit_cnt, bit_n;
    i2c_pkg::byte_op_t  op_r, op_n;   // data field doubles as shift register
    i2c_pkg::byte_rsp_t rsp_r, rsp_n;
    logic done_n;
    logic scl_n;
    logic sda_n;

    assign op_ready = (state == i2c_pkg::ENG_IDLE);
    assign op_rsp   = rsp_r;

    always_comb
    begin
        state_n = state;
        q_n     = q_cnt;
        phase_n = phase;
        bit_n   = bit_cnt;
        op_n    = op_r;
        rsp_n   = rsp_r;
        done_n  = 1'b0;
        if (state == i2c_pkg::ENG_IDLE)
        begin
            if (op_valid)
            begin
                op_n    = op;
                q_n     = '0;
                phase_n = 2'd0;
                bit_n   = 4'd0;
                case (op.opcode)
                    i2c_pkg::OP_START, i2c_pkg::OP_RESTART: state_n = i2c_pkg::ENG_START;
                    i2c_pkg::OP_STOP:                       state_n = i2c_pkg::ENG_STOP;
                    default:                                state_n = i2c_pkg::ENG_XFER;
                endcase
            end
        end
        else if (q_cnt == i2c_pkg::SCL_QLAST)
        begin
            q_n     = '0;
            phase_n = phase + 2'd1;
            // sample late in scl high
            if (state == i2c_pkg::ENG_XFER && phase == 2'd1)
            begin
                if (bit_cnt == i2c_pkg::ACK_BIT)
                    rsp_n.slave_ack = !sda_in;
                else
                    rsp_n.data = {rsp_r.data[6:0], sda_in};
            end
            if (phase == 2'd3)
            begin
                if (state != i2c_pkg::ENG_XFER || bit_cnt == i2c_pkg::ACK_BIT)
                begin
                    state_n = i2c_pkg::ENG_IDLE;
                    done_n  = 1'b1;
                end
                else
                begin
                    bit_n       = bit_cnt + 4'd1;
                    op_n.data   = {op_r.data[6:0], 1'b0}; // msb first
                end
            end
        end
        else
            q_n = q_cnt + 1'b1;
    end

    // pin levels for the state being entered
    always_comb
    begin
        scl_n = scl;
        sda_n = sda_drive_low;
        case (state_n)
            i2c_pkg::ENG_START:
            begin
                // restart begins with scl low after the previous byte
                if (phase_n == 2'd0)
                    scl_n = (op_n.opcode == i2c_pkg::OP_START);
                else
                    scl_n = (phase_n != 2'd3);
                sda_n = phase_n[1];
            end
            i2c_pkg::ENG_STOP:
            begin
                scl_n = (phase_n != 2'd0);
                sda_n = !phase_n[1];
            end
            i2c_pkg::ENG_XFER:
            begin
                scl_n = phase_n[0] ^ phase_n[1];
                if (bit_n == i2c_pkg::ACK_BIT)
                    sda_n = (op_n.opcode == i2c_pkg::OP_READ) && op_n.master_ack;
                else
                    sda_n = (op_n.opcode == i2c_pkg::OP_WRITE) && !op_n.data[7];
            end
            default: ; // idle holds the bus
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= i2c_pkg::ENG_IDLE;
            q_cnt         <= '0;
            phase         <= 2'd0;
            bit_cnt       <= 4'd0;
            op_done       <= 1'b0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end
        else
        begin
            state         <= state_n;
            q_cnt         <= q_n;
            phase         <= phase_n;
            bit_cnt       <= bit_n;
            op_done       <= done_n;
            scl           <= scl_n;
            sda_drive_low <= sda_n;
        end
    end

    always_ff @(posedge CLK)
    begin
        op_r  <= op_n;
        rsp_r <= rsp_n;
    end

    // data only moves under scl low, start and stop excepted
    assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $changed(sda_drive_low))
        |-> (state == i2c_pkg::ENG_START || state == i2c_pkg::ENG_STOP))
        else $error("sda changed while scl high");

endmodule

//--- design/eeprom_ctrl_top.sv
`timescale 1ns/1ps

module eeprom_ctrl_top (
    input  logic        CLK,
    input  logic        RESET,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic        scl,
    output logic        sda_drive_low,
    input  logic        sda_in
);

    logic                    cmd_valid;
    logic                    cmd_ready;
    eeprom_pkg::eeprom_cmd_t cmd;
    logic                    rsp_valid;
    eeprom_pkg::eeprom_rsp_t rsp;
    logic                    op_valid;
    logic                    op_ready;
    i2c_pkg::byte_op_t       op;
    logic                    op_done;
    i2c_pkg::byte_rsp_t      op_rsp;

    eeprom_axil_regs axil_regs_inst (
        .CLK(CLK), .RESET(RESET),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
        .rsp_valid(rsp_valid), .rsp(rsp)
    );

    eeprom_sequencer sequencer_inst (
        .CLK(CLK), .RESET(RESET),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
        .rsp_valid(rsp_valid), .rsp(rsp),
        .op_valid(op_valid), .op_ready(op_ready), .op(op),
        .op_done(op_done), .op_rsp(op_rsp)
    );

    i2c_bit_engine bit_engine_inst (
        .CLK(CLK), .RESET(RESET),
        .op_valid(op_valid), .op_ready(op_ready), .op(op),
        .op_done(op_done), .op_rsp(op_rsp),
        .scl(scl), .sda_drive_low(sda_drive_low), .sda_in(sda_in)
    );

endmodule

//--- verification/i2c_eeprom_model.sv
`timescale 1ns/1ps

module i2c_eeprom_model (
    input  logic scl,
    input  logic sda,
    output logic sda_drive_low,
    input  logic ack_enable
);

    localparam logic [3:0] DEVICE_TYPE = 4'b1010;

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_DATA,
        M_TURN,   // read control byte acked, data goes out next
        M_SEND,
        M_IGNORE
    } mode_e;

    logic [7:0] mem [0:2047];
    mode_e      mode = M_IDLE;
    int         cnt = 0;          // scl high pulses in this byte
    logic [7:0] shift = 8'h00;
    logic [7:0] tx_byte = 8'h00;
    logic [2:0] page = 3'd0;
    logic [7:0] word = 8'h00;
    logic       master_ack = 1'b0;
    logic       drive_low = 1'b0;
    logic       scl_prev = 1'b1;

    assign sda_drive_low = drive_low;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[11'(i)] = 8'hFF; // erased cells
    end

    // called on the falling scl edge after the eighth data bit
    task automatic take_byte;
        if (!ack_enable)
            mode = M_IGNORE;
        case (mode)
            M_CTRL:
            begin
                if (shift[7:4] != DEVICE_TYPE)
                    mode = M_IGNORE;
                else
                begin
                    page = shift[3:1];
                    mode = shift[0] ? M_TURN : M_ADDR;
                end
            end
            M_ADDR:
            begin
                word = shift;
                mode = M_DATA;
            end
            M_DATA:
            begin
                mem[{page, word}] = shift;
                word = word + 8'd1;
            end
            default: ;
        endcase
        drive_low = (mode != M_IGNORE);
    endtask

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (scl == scl_prev)
        begin
            // sda moved while scl stayed put
            if (scl && !sda)
            begin
                mode      = M_CTRL; // start or repeated start
                cnt       = 0;
                drive_low = 1'b0;
            end
            else if (scl)
            begin
                mode      = M_IDLE;
                drive_low = 1'b0;
            end
        end
        else if (mode != M_IDLE)
        begin
            if (scl)
            begin
                if (cnt < 8)
                    shift = {shift[6:0], sda};
                else
                    master_ack = !sda;
                cnt = cnt + 1;
            end
            else if (cnt == 8)
            begin
                if (mode == M_SEND)
                    drive_low = 1'b0; // master answers in the ninth clock
                else
                    take_byte();
            end
            else if (cnt == 9)
            begin
                cnt       = 0;
                drive_low = 1'b0;
                if (mode == M_TURN || (mode == M_SEND && master_ack))
                begin
                    if (mode == M_SEND)
                        word = word + 8'd1;
                    mode      = M_SEND;
                    tx_byte   = mem[{page, word}];
                    drive_low = !tx_byte[7];
                end
                else if (mode == M_SEND)
                    mode = M_IDLE; // nack ends the read
            end
            else if (cnt > 0 && mode == M_SEND)
            begin
                tx_byte   = {tx_byte[6:0], 1'b0};
                drive_low = !tx_byte[7];
            end
        end
        scl_prev = scl;
    end

endmodule

//--- verification/eeprom_ctrl_tb.sv
`timescale 1ns/1ps

module eeprom_ctrl_tb;

    localparam int RANDOM_WRITES   = 40;
    localparam int XFER_COUNT      = 90; // all transactions issued below
    localparam int CYCLES_PER_XFER = 50 * 4 * i2c_pkg::SCL_QUARTER;
    localparam int TIMEOUT_CYCLES  = 2 * XFER_COUNT * CYCLES_PER_XFER;

    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic        CLK = 1'b0;
    logic        RESET;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        scl;
    logic        sda_drive_low;
    logic        model_sda_low;
    logic        sda_line;
    logic        ack_enable;

    logic [7:0]  shadow [logic [10:0]];
    logic [10:0] read_addr_q [$];
    logic [7:0]  read_data_q [$];
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;

    // wired-and with pull-up
    assign sda_line = !(sda_drive_low || model_sda_low);

    always #50 CLK = ~CLK;

    always @(posedge CLK)
        cycle_count <= cycle_count + 1;

    eeprom_ctrl_top eeprom_ctrl_top_inst (
        .CLK(CLK), .RESET(RESET),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .scl(scl), .sda_drive_low(sda_drive_low), .sda_in(sda_line)
    );

    i2c_eeprom_model eeprom_model_inst (
        .scl(scl),
        .sda(sda_line),
        .sda_drive_low(model_sda_low),
        .ack_enable(ack_enable)
    );

    function automatic logic [7:0] expected_byte(input logic [10:0] addr);
        if (shadow.exists(addr))
            return shadow[addr];
        return 8'hFF; // never written
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("[ERROR] %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // all bus tasks start and end 1 ns after a rising edge
    task automatic write_reg(input logic [3:0] offset, input logic [31:0] value);
        awaddr  = offset;
        wdata   = value;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        #1;
        while (!(awready && wready))
        begin
            @(posedge CLK);
            #2;
        end
        @(posedge CLK); // both channels taken here
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_value("bvalid", 32'(bvalid), 32'h1);
        check_value($sformatf("bresp[0x%0h]", offset), 32'(bresp), 32'(OKAY));
        bready = 1'b1;
        @(posedge CLK);
        #1;
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] offset, output logic [31:0] value,
                            output logic [1:0] resp);
        araddr  = offset;
        arvalid = 1'b1;
        #1;
        while (!arready)
        begin
            @(posedge CLK);
            #2;
        end
        @(posedge CLK); // address taken here
        #1;
        arvalid = 1'b0;
        check_value("rvalid", 32'(rvalid), 32'h1);
        value   = rdata;
        resp    = rresp;
        rready  = 1'b1;
        @(posedge CLK);
        #1;
        rready = 1'b0;
    endtask

    task automatic wait_idle(output logic [31:0] status);
        logic [1:0] resp;
        do
            read_reg(eeprom_pkg::REG_STATUS, status, resp);
        while (status[0]);
    endtask

    task automatic store_byte(input logic [10:0] addr, input logic [7:0] data,
                              input logic expect_nack);
        logic [31:0] status;
        write_reg(eeprom_pkg::REG_ADDR, 32'(addr));
        write_reg(eeprom_pkg::REG_WDATA, 32'(data));
        write_reg(eeprom_pkg::REG_CTRL, 32'h1);
        wait_idle(status);
        check_value("status.nack_error", 32'(status[1]), 32'(expect_nack));
        if (!expect_nack)
            shadow[addr] = data;
    endtask

    task automatic fetch_byte(input logic [10:0] addr, input logic expect_nack);
        logic [31:0] status;
        write_reg(eeprom_pkg::REG_ADDR, 32'(addr));
        write_reg(eeprom_pkg::REG_CTRL, 32'h2);
        wait_idle(status);
        check_value("status.nack_error", 32'(status[1]), 32'(expect_nack));
        if (!expect_nack)
        begin
            read_addr_q.push_back(addr);
            read_data_q.push_back(status[15:8]);
        end
    endtask

    always @(posedge CLK)
    begin : compare_reads
        logic [10:0] addr;
        logic [7:0]  data;
        while (read_addr_q.size() > 0)
        begin
            addr = read_addr_q.pop_front();
            data = read_data_q.pop_front();
            check_value($sformatf("rdata[0x%03h]", addr), 32'(data),
                        32'(expected_byte(addr)));
        end
    end

    initial
    begin : watchdog
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, the controller never went idle", cycle_count);
        $display("checks: %0d  errors: %0d", check_count, error_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin : stimulus
        logic [31:0] value;
        logic [1:0]  resp;
        logic [10:0] addrs [$];
        void'($urandom(32'h4220));
        RESET      = 1'b1;
        awaddr     = 4'h0;
        awvalid    = 1'b0;
        wdata      = 32'h0;
        wstrb      = 4'h0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = 4'h0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        ack_enable = 1'b1;
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;

        read_reg(eeprom_pkg::REG_STATUS, value, resp);
        check_value("status.busy", 32'(value[0]), 32'h0);
        check_value("status.nack_error", 32'(value[1]), 32'h0);

        // lowest and highest cells sit in different device pages
        store_byte(11'h000, 8'hA5, 1'b0);
        fetch_byte(11'h000, 1'b0);
        store_byte(11'h7FF, 8'h5A, 1'b0);
        fetch_byte(11'h7FF, 1'b0);

        for (int i = 0; i < RANDOM_WRITES; i++)
        begin
            addrs.push_back(11'($urandom()));
            store_byte(addrs[i], 8'($urandom()), 1'b0);
        end
        foreach (addrs[i])
            fetch_byte(addrs[i], 1'b0);

        // silent slave, cell must keep its old value
        ack_enable = 1'b0;
        store_byte(addrs[0], ~expected_byte(addrs[0]), 1'b1);
        fetch_byte(addrs[0], 1'b1);
        ack_enable = 1'b1;
        fetch_byte(addrs[0], 1'b0);

        write_reg(eeprom_pkg::REG_ADDR, 32'h2B7);
        write_reg(eeprom_pkg::REG_WDATA, 32'h3C);
        write_reg(eeprom_pkg::REG_CTRL, 32'h1);
        read_reg(eeprom_pkg::REG_STATUS, value, resp);
        check_value("status.busy", 32'(value[0]), 32'h1);
        write_reg(eeprom_pkg::REG_WDATA, 32'hC3);
        write_reg(eeprom_pkg::REG_CTRL, 32'h1); // dropped while busy
        wait_idle(value);
        shadow[11'h2B7] = 8'h3C;
        fetch_byte(11'h2B7, 1'b0);

        read_reg(4'h6, value, resp);
        check_value("rresp[0x6]", 32'(resp), 32'(SLVERR));
        write_reg(eeprom_pkg::REG_ADDR, 32'h5A3);
        write_reg(eeprom_pkg::REG_WDATA, 32'h96);
        read_reg(eeprom_pkg::REG_ADDR, value, resp);
        check_value("addr_reg", value, 32'h5A3);
        read_reg(eeprom_pkg::REG_WDATA, value, resp);
        check_value("wdata_reg", value, 32'h96);

        // let the compare process see the last read
        repeat (2) @(posedge CLK);
        #1;
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- filelist.f
design/i2c_pkg.sv
design/eeprom_pkg.sv
design/eeprom_axil_regs.sv
design/eeprom_sequencer.sv
design/i2c_bit_engine.sv
design/eeprom_ctrl_top.sv
verification/i2c_eeprom_model.sv
verification/eeprom_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= eeprom_ctrl_tb
SEED      ?= 0
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

PASS_TEXT := *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
